//--- Makefile
TOP = llc_lookup_tb
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

//--- bench/llc_lookup_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port assertions for the LLC lookup top: credits, reset, hit/evict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module llc_lookup_properties #(
    parameter int RESP_DEPTH = 2
) (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_credit,
    input logic resp_valid,
    input logic resp_credit,
    input logic resp_hit,
    input logic resp_evict
);

    // credits held by each side of the top-level links
    int up_cnt;
    int down_cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            up_cnt   <= 1;
            down_cnt <= RESP_DEPTH;
        end else begin
            up_cnt   <= up_cnt + int'(req_credit) - int'(req_valid);
            down_cnt <= down_cnt + int'(resp_credit) - int'(resp_valid);
        end
    end

    a_req_credit: assert property (@(posedge clk) disable iff (!rst)
        req_valid |-> up_cnt > 0)
        else $error("request sent without upstream credit");

    a_resp_credit: assert property (@(posedge clk) disable iff (!rst)
        resp_valid |-> down_cnt > 0)
        else $error("response sent without downstream credit");

    a_reset_quiet: assert property (@(posedge clk)
        !rst |-> (!req_credit && !resp_valid))
        else $error("control outputs active during reset");

    a_hit_evict: assert property (@(posedge clk) disable iff (!rst)
        resp_valid |-> !(resp_hit && resp_evict))
        else $error("response flags both hit and evict");

endmodule

`default_nettype wire

//--- bench/llc_lookup_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the LLC lookup top with stimulus, reference model and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module llc_lookup_tb import llc_pkg::*; ();

    localparam int NUM_BANKS      = 2;
    localparam int N_DIRECTED     = 27;
    localparam int N_RANDOM       = 80;
    localparam int TIMEOUT_CYCLES = 40 * (N_DIRECTED + N_RANDOM) + 200;

    logic      clk = 1'b0;
    logic      rst;
    logic      req_valid;
    llc_op_t   req_op;
    llc_addr_t req_addr;
    logic      req_credit;
    logic      resp_valid;
    logic      resp_hit;
    llc_way_t  resp_way;
    logic      resp_evict;
    llc_tag_t  resp_victim_tag;
    llc_addr_t resp_addr;
    logic      resp_credit = 1'b0;

    int cycle = 0;
    int up_cred;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int credit_max = 3;
    int seed = 32'hf8c6_bc5e;
    int credit_seed = 32'hf8c6_bc5e;
    int credit_due [$];

    // reference state per bank and set
    llc_state_t m_state [NUM_BANKS][LLC_SETS][LLC_WAYS];
    llc_tag_t   m_tag   [NUM_BANKS][LLC_SETS][LLC_WAYS];
    llc_way_t   m_ptr   [NUM_BANKS][LLC_SETS];
    llc_resp_t  exp_q   [NUM_BANKS][$];

    llc_lookup_top UUT (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_credit      (req_credit),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_way        (resp_way),
        .resp_evict      (resp_evict),
        .resp_victim_tag (resp_victim_tag),
        .resp_addr       (resp_addr),
        .resp_credit     (resp_credit)
    );

    bind llc_lookup_top llc_lookup_properties #(
        .RESP_DEPTH (RESP_DEPTH)
    ) u_props (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp_credit (resp_credit),
        .resp_hit    (resp_hit),
        .resp_evict  (resp_evict)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("timeout: responses still missing after %0d cycles", cycle);
            $display("Errors found");
            $finish;
        end
    end

    // upstream credits, one returned per req_credit pulse
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            up_cred <= 1;
        end else begin
            up_cred <= up_cred + int'(req_credit) - int'(req_valid);
        end
    end

    task automatic predict(input llc_op_t op, input llc_tag_t tag, input llc_set_t set,
                           input logic bank, output llc_resp_t r);
        int b;
        int s;
        int w;
        int way;
        logic hit;
        logic victim;
        logic alloc;
        b      = int'(bank);
        s      = int'(set);
        way    = -1;
        hit    = 1'b0;
        victim = 1'b0;
        for (int i = 0; i < LLC_WAYS; i++) begin
            if (way < 0 && m_state[b][s][i] != INVALID && m_tag[b][s][i] == tag) begin
                way = i;
                hit = 1'b1;
            end
        end
        for (int i = 0; i < LLC_WAYS; i++) begin
            if (way < 0 && m_state[b][s][i] == INVALID) begin
                way = i;
            end
        end
        // victim search walks upward from the eviction pointer
        for (int k = 0; k < LLC_WAYS; k++) begin
            w = (int'(m_ptr[b][s]) + k) % LLC_WAYS;
            if (way < 0 && m_state[b][s][w] == VALID) begin
                way    = w;
                victim = 1'b1;
            end
        end
        for (int k = 0; k < LLC_WAYS; k++) begin
            w = (int'(m_ptr[b][s]) + k) % LLC_WAYS;
            if (way < 0 && m_state[b][s][w] != SD) begin
                way    = w;
                victim = 1'b1;
            end
        end
        if (way < 0) begin
            way    = int'(m_ptr[b][s]);
            victim = 1'b1;
        end
        alloc          = !hit && (op == OP_LOOKUP || op == OP_PIN);
        r.addr         = {tag, set, bank};
        r.hit          = hit;
        r.way          = llc_way_t'(way);
        r.evict        = alloc && victim;
        r.victim_tag   = r.evict ? m_tag[b][s][way] : '0;
        case (op)
            OP_LOOKUP: if (alloc) m_state[b][s][way] = VALID;
            OP_PIN:    m_state[b][s][way] = SD;
            OP_UNPIN:  if (hit && m_state[b][s][way] == SD) m_state[b][s][way] = VALID;
            default:   if (hit) m_state[b][s][way] = INVALID;
        endcase
        if (alloc) begin
            m_tag[b][s][way] = tag;
        end
        if (r.evict) begin
            m_ptr[b][s] = llc_way_t'((way + 1) % LLC_WAYS);
        end
    endtask

    // entered and left on a falling edge
    task automatic issue(input llc_op_t op, input llc_tag_t tag, input llc_set_t set,
                         input logic bank);
        llc_resp_t expected;
        while (up_cred == 0) begin
            @(negedge clk);
        end
        predict(op, tag, set, bank, expected);
        exp_q[int'(bank)].push_back(expected);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = {tag, set, bank};
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_start);
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(negedge clk);
        end
        tests++;
        $display("test %0d %s: done, %0d errors", tests, name, errors - err_start);
    endtask

    // response check and delayed downstream credit return
    always @(negedge clk) begin : monitor
        llc_resp_t act;
        llc_resp_t expected;
        int b;
        int due;
        resp_credit = 1'b0;
        if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            resp_credit = 1'b1;
        end
        if (resp_valid) begin
            act = '{addr: resp_addr, hit: resp_hit, way: resp_way,
                    evict: resp_evict, victim_tag: resp_victim_tag};
            b = int'(resp_addr[0]);
            checks++;
            assert (exp_q[b].size() != 0) else begin
                errors++;
                $display("unexpected response for address %h from bank %0d", resp_addr, b);
            end
            if (exp_q[b].size() != 0) begin
                expected = exp_q[b].pop_front();
                assert (act == expected) else begin
                    errors++;
                    $display({"** Error (%0t): bank %0d expected addr %h hit %b way %0d",
                              " evict %b tag %h, got addr %h hit %b way %0d evict %b tag %h"},
                             $time, b, expected.addr, expected.hit, expected.way,
                             expected.evict, expected.victim_tag, act.addr, act.hit,
                             act.way, act.evict, act.victim_tag);
                end
            end
            due = cycle + 1 + int'({$random(credit_seed)} % credit_max);
            if (credit_due.size() != 0 && due < credit_due[$]) begin
                due = credit_due[$];
            end
            credit_due.push_back(due);
        end
    end

    initial begin
        logic [31:0] r;
        int e0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_LOOKUP;
        req_addr  = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                m_ptr[b][s] = '0;
                for (int w = 0; w < LLC_WAYS; w++) begin
                    m_state[b][s][w] = INVALID;
                    m_tag[b][s][w]   = '0;
                end
            end
        end
        #1 rst = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b1;

        e0 = errors;
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < LLC_WAYS; i++) begin
                issue(OP_LOOKUP, llc_tag_t'(8'h10 + i), 2'd0, 1'b0);
            end
        end
        finish_test("fill and hit", e0);

        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            issue(OP_LOOKUP, llc_tag_t'(8'h20 + i), 2'd0, 1'b0);
        end
        finish_test("rotating eviction", e0);

        // two pinned ways, then a fully pinned set
        e0 = errors;
        issue(OP_PIN, 8'h30, 2'd2, 1'b1);
        issue(OP_PIN, 8'h31, 2'd2, 1'b1);
        for (int i = 2; i < 6; i++) begin
            issue(OP_LOOKUP, llc_tag_t'(8'h30 + i), 2'd2, 1'b1);
        end
        issue(OP_PIN, 8'h35, 2'd2, 1'b1);
        issue(OP_PIN, 8'h36, 2'd2, 1'b1);
        issue(OP_LOOKUP, 8'h37, 2'd2, 1'b1);
        finish_test("pinning", e0);

        e0 = errors;
        issue(OP_UNPIN, 8'h30, 2'd2, 1'b1);
        issue(OP_UNPIN, 8'h99, 2'd2, 1'b1);
        issue(OP_UNPIN, 8'h37, 2'd2, 1'b1);
        issue(OP_LOOKUP, 8'h38, 2'd2, 1'b1);
        issue(OP_INVAL, 8'h31, 2'd2, 1'b1);
        issue(OP_INVAL, 8'h99, 2'd2, 1'b1);
        issue(OP_LOOKUP, 8'h39, 2'd2, 1'b1);
        finish_test("unpin and invalidate", e0);

        // small tag pool keeps hits frequent
        e0 = errors;
        credit_max = 8;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            issue(llc_op_t'(r[1:0]), llc_tag_t'(8'h40 + r[4:2]), r[6:5], r[7]);
        end
        finish_test("random mix with back-pressure", e0);

        $display("tests %0d, responses checked %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/llc_pkg.sv
src/llc_lookup_way.sv
src/llc_bank.sv
src/llc_req_dispatch.sv
src/llc_resp_merge.sv
src/llc_lookup_top.sv
bench/llc_lookup_properties.sv
bench/llc_lookup_tb.sv

//--- src/llc_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one LLC bank: request queue, tag/state/pointer arrays, 3-stage FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module llc_bank import llc_pkg::*; #(
    parameter int BANK_CREDITS = 2,
    parameter int RESP_DEPTH   = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  llc_req_t  req,
    output logic      req_credit,
    output logic      resp_valid,
    output llc_resp_t resp,
    input  logic      resp_credit
);

    localparam int QW  = (BANK_CREDITS > 1) ? $clog2(BANK_CREDITS) : 1;
    localparam int QCW = $clog2(BANK_CREDITS + 1);
    localparam int MCW = $clog2(RESP_DEPTH + 1);

    typedef enum logic [1:0] {IDLE, READ, LOOK, WRITE} stage_t;

    stage_t         stage;
    llc_req_t       q_mem [BANK_CREDITS];
    logic [QW-1:0]  q_wp;
    logic [QW-1:0]  q_rp;
    logic [QCW-1:0] q_cnt;
    logic [MCW-1:0] m_cnt;
    logic           pop;
    logic           send;
    logic           alloc;

    llc_tag_t   tag_arr   [LLC_SETS][LLC_WAYS];
    llc_state_t state_arr [LLC_SETS][LLC_WAYS];
    llc_way_t   ptr_arr   [LLC_SETS];

    llc_req_t   cur;
    llc_set_t   cur_set;
    llc_tag_t   tags_buf   [LLC_WAYS];
    llc_state_t states_buf [LLC_WAYS];
    llc_way_t   evict_way_buf;
    llc_way_t   lk_way;
    logic       lk_evict;
    logic       lk_hit;
    llc_state_t new_state;

    assign cur_set    = addr_set(cur.addr);
    assign send       = (stage == WRITE) && (m_cnt != '0);
    // next request only once the previous one has written back
    assign pop        = (q_cnt != '0) && ((stage == IDLE) || send);
    assign req_credit = pop;
    assign resp_valid = send;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stage <= IDLE;
            q_wp  <= '0;
            q_rp  <= '0;
            q_cnt <= '0;
            m_cnt <= MCW'(RESP_DEPTH);
        end else begin
            case (stage)
                IDLE:    stage <= pop ? READ : IDLE;
                READ:    stage <= LOOK;
                LOOK:    stage <= WRITE;
                default: stage <= send ? (pop ? READ : IDLE) : WRITE;
            endcase
            if (req_valid) begin
                q_wp <= (q_wp == QW'(BANK_CREDITS - 1)) ? '0 : q_wp + 1'b1;
            end
            if (pop) begin
                q_rp <= (q_rp == QW'(BANK_CREDITS - 1)) ? '0 : q_rp + 1'b1;
            end
            q_cnt <= q_cnt + QCW'(req_valid) - QCW'(pop);
            m_cnt <= m_cnt - MCW'(send) + MCW'(resp_credit);
        end
    end

    // queue payload and lookup buffers
    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_mem[q_wp] <= req;
        end
        if (pop) begin
            cur <= q_mem[q_rp];
        end
        if (stage == READ) begin
            tags_buf      <= tag_arr[cur_set];
            states_buf    <= state_arr[cur_set];
            evict_way_buf <= ptr_arr[cur_set];
        end
        if (send && alloc) begin
            tag_arr[cur_set][lk_way] <= addr_tag(cur.addr);
        end
    end

    llc_lookup_way u_lookup (
        .clk           (clk),
        .rst           (rst),
        .tag           (addr_tag(cur.addr)),
        .tags_buf      (tags_buf),
        .states_buf    (states_buf),
        .evict_way_buf (evict_way_buf),
        .lookup_en     (stage == LOOK),
        .way           (lk_way),
        .evict         (lk_evict),
        .hit           (lk_hit)
    );

    // opcode rules on the chosen way
    always_comb begin
        alloc     = 1'b0;
        new_state = states_buf[lk_way];
        case (cur.op)
            OP_LOOKUP: begin
                alloc = !lk_hit;
                if (!lk_hit) begin
                    new_state = VALID;
                end
            end
            OP_PIN: begin
                alloc     = !lk_hit;
                new_state = SD;
            end
            OP_UNPIN: begin
                if (lk_hit && (states_buf[lk_way] == SD)) begin
                    new_state = VALID;
                end
            end
            default: begin
                if (lk_hit) begin
                    new_state = INVALID;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                ptr_arr[s] <= '0;
                for (int w = 0; w < LLC_WAYS; w++) begin
                    state_arr[s][w] <= INVALID;
                end
            end
        end else if (send) begin
            state_arr[cur_set][lk_way] <= new_state;
            if (alloc && lk_evict) begin
                ptr_arr[cur_set] <= lk_way + 1'b1;
            end
        end
    end

    always_comb begin
        resp.addr       = cur.addr;
        resp.hit        = lk_hit;
        resp.way        = lk_way;
        resp.evict      = alloc && lk_evict;
        resp.victim_tag = (alloc && lk_evict) ? tags_buf[lk_way] : '0;
    end

endmodule

`default_nettype wire

//--- src/llc_lookup_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// banked LLC lookup top: dispatcher, bank array, response merger
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module llc_lookup_top import llc_pkg::*; #(
    parameter int NUM_BANKS    = 2,
    parameter int BANK_CREDITS = 2,
    parameter int RESP_DEPTH   = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  llc_op_t   req_op,
    input  llc_addr_t req_addr,
    output logic      req_credit,
    output logic      resp_valid,
    output logic      resp_hit,
    output llc_way_t  resp_way,
    output logic      resp_evict,
    output llc_tag_t  resp_victim_tag,
    output llc_addr_t resp_addr,
    input  logic      resp_credit
);

    // bank select comes straight from the low address bits
    if (NUM_BANKS != (1 << BANK_BITS)) begin : g_bank_check
        $error("NUM_BANKS must equal 2**BANK_BITS");
    end

    logic [NUM_BANKS-1:0] bank_req_valid;
    llc_req_t             bank_req;
    logic [NUM_BANKS-1:0] bank_credit;
    logic [NUM_BANKS-1:0] resp_in_valid;
    llc_resp_t            resp_in [NUM_BANKS];
    logic [NUM_BANKS-1:0] merge_credit;

    llc_req_dispatch #(
        .NUM_BANKS    (NUM_BANKS),
        .BANK_CREDITS (BANK_CREDITS)
    ) u_dispatch (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_credit     (req_credit),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_credit    (bank_credit)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        llc_bank #(
            .BANK_CREDITS (BANK_CREDITS),
            .RESP_DEPTH   (RESP_DEPTH)
        ) u_bank (
            .clk         (clk),
            .rst         (rst),
            .req_valid   (bank_req_valid[b]),
            .req         (bank_req),
            .req_credit  (bank_credit[b]),
            .resp_valid  (resp_in_valid[b]),
            .resp        (resp_in[b]),
            .resp_credit (merge_credit[b])
        );
    end

    llc_resp_merge #(
        .NUM_BANKS  (NUM_BANKS),
        .RESP_DEPTH (RESP_DEPTH)
    ) u_merge (
        .clk             (clk),
        .rst             (rst),
        .resp_in_valid   (resp_in_valid),
        .resp_in         (resp_in),
        .merge_credit    (merge_credit),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_way        (resp_way),
        .resp_evict      (resp_evict),
        .resp_victim_tag (resp_victim_tag),
        .resp_addr       (resp_addr),
        .resp_credit     (resp_credit)
    );

endmodule

`default_nettype wire

//--- src/llc_lookup_way.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// way selection: hit, empty and rotating victim, registered result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module llc_lookup_way import llc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  llc_tag_t   tag,
    input  llc_tag_t   tags_buf [LLC_WAYS],
    input  llc_state_t states_buf [LLC_WAYS],
    input  llc_way_t   evict_way_buf,
    input  logic       lookup_en,
    output llc_way_t   way,
    output logic       evict,
    output logic       hit
);

    logic [LLC_WAYS-1:0] hit_vec;
    logic [LLC_WAYS-1:0] empty_vec;
    logic [LLC_WAYS-1:0] valid_rot;
    logic [LLC_WAYS-1:0] not_sd_rot;
    llc_way_t hit_way;
    llc_way_t empty_way;
    llc_way_t valid_off;
    llc_way_t not_sd_off;
    llc_way_t way_next;
    logic     evict_next;

    // rotated vectors start at the eviction pointer
    always_comb begin
        for (int i = 0; i < LLC_WAYS; i++) begin
            hit_vec[i]    = (tags_buf[i] == tag) && (states_buf[i] != INVALID);
            empty_vec[i]  = (states_buf[i] == INVALID);
            valid_rot[i]  = (states_buf[llc_way_t'(i) + evict_way_buf] == VALID);
            not_sd_rot[i] = (states_buf[llc_way_t'(i) + evict_way_buf] != SD);
        end
    end

    // lowest set bit wins in each vector
    always_comb begin
        hit_way    = '0;
        empty_way  = '0;
        valid_off  = '0;
        not_sd_off = '0;
        for (int j = LLC_WAYS - 1; j >= 0; j--) begin
            if (hit_vec[j]) begin
                hit_way = llc_way_t'(j);
            end
            if (empty_vec[j]) begin
                empty_way = llc_way_t'(j);
            end
            if (valid_rot[j]) begin
                valid_off = llc_way_t'(j);
            end
            if (not_sd_rot[j]) begin
                not_sd_off = llc_way_t'(j);
            end
        end
    end

    always_comb begin
        evict_next = 1'b1;
        if (|hit_vec) begin
            way_next   = hit_way;
            evict_next = 1'b0;
        end else if (|empty_vec) begin
            way_next   = empty_way;
            evict_next = 1'b0;
        end else if (|valid_rot) begin
            way_next = valid_off + evict_way_buf;
        end else if (|not_sd_rot) begin
            way_next = not_sd_off + evict_way_buf;
        end else begin
            // whole set pinned
            way_next = evict_way_buf;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way   <= '0;
            evict <= 1'b0;
            hit   <= 1'b0;
        end else if (lookup_en) begin
            way   <= way_next;
            evict <= evict_next;
            hit   <= |hit_vec;
        end
    end

endmodule

`default_nettype wire

//--- src/llc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LLC lookup package: field widths, line state and opcode enums,
// request and response structs, address field helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package llc_pkg;

    localparam int LLC_WAYS     = 4;
    localparam int LLC_WAY_BITS = 2;
    localparam int TAG_BITS     = 8;
    localparam int SET_BITS     = 2;
    localparam int BANK_BITS    = 1;
    localparam int ADDR_BITS    = TAG_BITS + SET_BITS + BANK_BITS;
    localparam int LLC_SETS     = 1 << SET_BITS;

    typedef logic [TAG_BITS-1:0]     llc_tag_t;
    typedef logic [SET_BITS-1:0]     llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;
    typedef logic [ADDR_BITS-1:0]    llc_addr_t;

    // SD marks a pinned line
    typedef enum logic [1:0] {INVALID = 2'd0, VALID = 2'd1, SD = 2'd2} llc_state_t;

    typedef enum logic [1:0] {OP_LOOKUP, OP_PIN, OP_UNPIN, OP_INVAL} llc_op_t;

    typedef struct packed {
        llc_op_t   op;
        llc_addr_t addr;
    } llc_req_t;

    typedef struct packed {
        llc_addr_t addr;
        logic      hit;
        llc_way_t  way;
        logic      evict;
        llc_tag_t  victim_tag;
    } llc_resp_t;

    // address layout, tag on top, bank in the low bits
    function automatic llc_tag_t addr_tag(llc_addr_t a);
        return a[ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic llc_set_t addr_set(llc_addr_t a);
        return a[BANK_BITS +: SET_BITS];
    endfunction

    function automatic logic [BANK_BITS-1:0] addr_bank(llc_addr_t a);
        return a[BANK_BITS-1:0];
    endfunction

endpackage

`default_nettype wire

//--- src/llc_req_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request dispatcher: one-slot buffer, bank decode, bank credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module llc_req_dispatch import llc_pkg::*; #(
    parameter int NUM_BANKS    = 2,
    parameter int BANK_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  llc_op_t              req_op,
    input  llc_addr_t            req_addr,
    output logic                 req_credit,
    output logic [NUM_BANKS-1:0] bank_req_valid,
    output llc_req_t             bank_req,
    input  logic [NUM_BANKS-1:0] bank_credit
);

    localparam int CW = $clog2(BANK_CREDITS + 1);

    llc_req_t             slot;
    logic                 slot_valid;
    logic [BANK_BITS-1:0] target;
    logic [CW-1:0]        cnt [NUM_BANKS];
    logic                 fwd;

    assign target     = addr_bank(slot.addr);
    assign fwd        = slot_valid && (cnt[target] != '0);
    assign req_credit = fwd;
    assign bank_req   = slot;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_valid[b] = fwd && (target == BANK_BITS'(b));
        end
    end

    // a new request may land in the same cycle the slot drains
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_valid <= 1'b0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                cnt[b] <= CW'(BANK_CREDITS);
            end
        end else begin
            slot_valid <= req_valid || (slot_valid && !fwd);
            for (int b = 0; b < NUM_BANKS; b++) begin
                cnt[b] <= cnt[b] - CW'(bank_req_valid[b]) + CW'(bank_credit[b]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            slot <= '{op: req_op, addr: req_addr};
        end
    end

endmodule

`default_nettype wire

//--- src/llc_resp_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response merger: per-bank FIFOs, round-robin drain, output credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module llc_resp_merge import llc_pkg::*; #(
    parameter int NUM_BANKS  = 2,
    parameter int RESP_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_BANKS-1:0] resp_in_valid,
    input  llc_resp_t            resp_in [NUM_BANKS],
    output logic [NUM_BANKS-1:0] merge_credit,
    output logic                 resp_valid,
    output logic                 resp_hit,
    output llc_way_t             resp_way,
    output logic                 resp_evict,
    output llc_tag_t             resp_victim_tag,
    output llc_addr_t            resp_addr,
    input  logic                 resp_credit
);

    localparam int PW = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int CW = $clog2(RESP_DEPTH + 1);

    llc_resp_t            fifo [NUM_BANKS][RESP_DEPTH];
    logic [PW-1:0]        wp   [NUM_BANKS];
    logic [PW-1:0]        rp   [NUM_BANKS];
    logic [CW-1:0]        fcnt [NUM_BANKS];
    logic [CW-1:0]        down_cnt;
    logic [BANK_BITS-1:0] rr;
    logic [BANK_BITS-1:0] sel;
    logic                 found;
    llc_resp_t            head;

    // first non-empty buffer at or after rr
    always_comb begin
        logic [BANK_BITS-1:0] idx;
        sel   = rr;
        found = 1'b0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            idx = rr + BANK_BITS'(i);
            if (!found && (fcnt[idx] != '0)) begin
                sel   = idx;
                found = 1'b1;
            end
        end
    end

    assign resp_valid      = found && (down_cnt != '0);
    assign head            = fifo[sel][rp[sel]];
    assign resp_hit        = head.hit;
    assign resp_way        = head.way;
    assign resp_evict      = head.evict;
    assign resp_victim_tag = head.victim_tag;
    assign resp_addr       = head.addr;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            merge_credit[b] = resp_valid && (sel == BANK_BITS'(b));
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rr       <= '0;
            down_cnt <= CW'(RESP_DEPTH);
            for (int b = 0; b < NUM_BANKS; b++) begin
                wp[b]   <= '0;
                rp[b]   <= '0;
                fcnt[b] <= '0;
            end
        end else begin
            if (resp_valid) begin
                rr <= sel + 1'b1;
            end
            down_cnt <= down_cnt - CW'(resp_valid) + CW'(resp_credit);
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (resp_in_valid[b]) begin
                    wp[b] <= (wp[b] == PW'(RESP_DEPTH - 1)) ? '0 : wp[b] + 1'b1;
                end
                if (merge_credit[b]) begin
                    rp[b] <= (rp[b] == PW'(RESP_DEPTH - 1)) ? '0 : rp[b] + 1'b1;
                end
                fcnt[b] <= fcnt[b] + CW'(resp_in_valid[b]) - CW'(merge_credit[b]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (resp_in_valid[b]) begin
                fifo[b][wp[b]] <= resp_in[b];
            end
        end
    end

endmodule

`default_nettype wire
